// File: decode_stage.f
+incdir+include
hdl/decode_pkg.sv
hdl/issue_select.sv
hdl/arith_operand_gen.sv
hdl/mem_branch_operand_gen.sv
hdl/unit_issue_reg.sv
hdl/decode_stage.sv
sim/decode_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f decode_stage.f --top-module decode_stage_tb -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/Vdecode_stage_tb)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Regression passed" && exit 0 || exit 1

// File: sim/decode_stage_tb.sv
////////////////////
// Table-driven testbench for the decode and issue stage.
// Register file and units are modeled as plain input levels.
// Each entry waits at most 20 cycles for pop.
////////////////////

`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage_tb import decode_pkg::*; ();

    localparam int MAX_ENTRIES = 32;
    localparam int POP_TIMEOUT = 20;
    localparam int NONE = -1;
    localparam int ALU = `DEC_ALU_ID;
    localparam int LS = `DEC_LS_ID;
    localparam int BR = `DEC_BR_ID;
    localparam int MUL = `DEC_MUL_ID;
    localparam logic [3:0] ALL = 4'hF;
    localparam logic [3:0] NO_ALU = 4'hF ^ (4'h1 << `DEC_ALU_ID);

    logic clk;
    logic rst;
    logic fb_valid;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic pop;
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic rs1_conflict;
    logic rs2_conflict;
    logic alu_ready;
    logic ls_ready;
    logic br_ready;
    logic mul_ready;
    logic alu_request;
    logic ls_request;
    logic br_request;
    logic mul_request;
    alu_inputs_t alu_inputs;
    ls_inputs_t ls_inputs;
    branch_inputs_t br_inputs;
    mul_inputs_t mul_inputs;
    logic illegal_instruction;
    logic issued_rd;
    logic [4:0] rd_addr;

    // Stimulus and expected values, conflict is {rs2, rs1}
    logic [31:0] t_instr [MAX_ENTRIES];
    logic [31:0] t_pc [MAX_ENTRIES];
    logic [31:0] t_rs1 [MAX_ENTRIES];
    logic [31:0] t_rs2 [MAX_ENTRIES];
    logic [1:0] t_conflict [MAX_ENTRIES];
    logic [3:0] t_ready [MAX_ENTRIES];
    int t_unit [MAX_ENTRIES];
    logic t_illegal [MAX_ENTRIES];
    string t_field [MAX_ENTRIES];
    logic [32:0] t_expect [MAX_ENTRIES];
    // Expected register addresses as {rd, rs1, rs2}
    logic [14:0] t_regs [MAX_ENTRIES];
    int num_entries = 0;
    int errors = 0;
    int seed = 32'h6b96;

    decode_stage UUT (
        .clk                 (clk),
        .rst                 (rst),
        .fb_valid            (fb_valid),
        .instruction         (instruction),
        .pc                  (pc),
        .pop                 (pop),
        .rs1_addr            (rs1_addr),
        .rs2_addr            (rs2_addr),
        .rs1_data            (rs1_data),
        .rs2_data            (rs2_data),
        .rs1_conflict        (rs1_conflict),
        .rs2_conflict        (rs2_conflict),
        .alu_ready           (alu_ready),
        .ls_ready            (ls_ready),
        .br_ready            (br_ready),
        .mul_ready           (mul_ready),
        .alu_request         (alu_request),
        .alu_inputs          (alu_inputs),
        .ls_request          (ls_request),
        .ls_inputs           (ls_inputs),
        .br_request          (br_request),
        .br_inputs           (br_inputs),
        .mul_request         (mul_request),
        .mul_inputs          (mul_inputs),
        .illegal_instruction (illegal_instruction),
        .issued_rd           (issued_rd),
        .rd_addr             (rd_addr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////
    task automatic check_value(input string name, input logic [32:0] actual,
        input logic [32:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic add_entry(input logic [31:0] instr, input logic [31:0] pc_val,
        input logic [31:0] rs1, input logic [31:0] rs2, input logic [1:0] conflict,
        input logic [3:0] ready, input int unit, input logic illegal,
        input string field, input logic [32:0] expected, input logic [14:0] regs);
        t_instr[num_entries] = instr;
        t_pc[num_entries] = pc_val;
        t_rs1[num_entries] = rs1;
        t_rs2[num_entries] = rs2;
        t_conflict[num_entries] = conflict;
        t_ready[num_entries] = ready;
        t_unit[num_entries] = unit;
        t_illegal[num_entries] = illegal;
        t_field[num_entries] = field;
        t_expect[num_entries] = expected;
        t_regs[num_entries] = regs;
        num_entries++;
    endtask

    function automatic logic [3:0] requests();
        logic [3:0] req;
        req = '0;
        req[`DEC_ALU_ID] = alu_request;
        req[`DEC_LS_ID] = ls_request;
        req[`DEC_BR_ID] = br_request;
        req[`DEC_MUL_ID] = mul_request;
        return req;
    endfunction

    function automatic logic [3:0] expected_requests(input int unit);
        return (unit < 0) ? 4'b0000 : (4'b0001 << unit);
    endfunction

    // Branches and stores write no register, x0 never counts
    function automatic logic writes_rd(input logic [31:0] instr);
        logic is_branch;
        logic is_store;
        is_branch = (instr[6:0] == 7'b1100011);
        is_store = (instr[6:0] == 7'b0100011);
        return !is_branch && !is_store && (instr[11:7] != 5'd0);
    endfunction

    function automatic logic [32:0] field_value(input string name);
        if (name == "alu.in1") return alu_inputs.in1;
        else if (name == "alu.in2") return alu_inputs.in2;
        else if (name == "ls.address") return 33'(ls_inputs.address);
        else if (name == "ls.store_data") return 33'(ls_inputs.store_data);
        else if (name == "ls.load") return 33'(ls_inputs.load);
        else if (name == "ls.store") return 33'(ls_inputs.store);
        else if (name == "br.pc") return 33'(br_inputs.pc);
        else if (name == "br.jal") return 33'(br_inputs.jal);
        else if (name == "br.jalr") return 33'(br_inputs.jalr);
        else if (name == "br.use_signed") return 33'(br_inputs.use_signed);
        else if (name == "mul.op") return 33'(mul_inputs.op);
        return '0;
    endfunction

    ////////////////////
    // Stimulus table
    ////////////////////
    task automatic load_table();
        logic [31:0] ra;
        logic [31:0] rb;
        ra = $random(seed);
        rb = $random(seed);
        // Sign bits set so the extra operand bit is visible
        ra[31] = 1'b1;
        rb[31] = 1'b1;
        // ADDI x5, x1, -16 and NOP
        add_entry(32'hFF008293, 32'h0, 32'h10, 32'h0, 2'b00, ALL, ALU, 1'b0,
            "alu.in2", 33'h1_FFFF_FFF0, {5'd5, 5'd1, 5'd16});
        add_entry(32'h00000013, 32'h0, 32'h0, 32'h0, 2'b00, ALL, ALU, 1'b0,
            "alu.in2", 33'h0, {5'd0, 5'd0, 5'd0});
        // LUI x6, 0x12345 with rs2 conflict raised
        add_entry(32'h12345337, 32'h200, 32'hDEADBEEF, 32'h0, 2'b10, ALL, ALU, 1'b0,
            "alu.in1", 33'h0, {5'd6, 5'd8, 5'd3});
        add_entry(32'h12345337, 32'h0, 32'h0, 32'h0, 2'b00, ALL, ALU, 1'b0,
            "alu.in2", 33'h0_1234_5000, {5'd6, 5'd8, 5'd3});
        // JAL x1, +8
        add_entry(32'h008000EF, 32'h100, 32'h0, 32'h0, 2'b00, ALL, BR, 1'b0,
            "br.pc", 33'h100, {5'd1, 5'd0, 5'd8});
        add_entry(32'h008000EF, 32'h104, 32'h0, 32'h0, 2'b00, ALL, BR, 1'b0,
            "br.jal", 33'h1, {5'd1, 5'd0, 5'd8});
        // ADD and SLTU on random register data
        add_entry(32'h002083B3, 32'h0, ra, rb, 2'b00, ALL, ALU, 1'b0,
            "alu.in2", {rb[31], rb}, {5'd7, 5'd1, 5'd2});
        add_entry(32'h0020B3B3, 32'h0, ra, rb, 2'b00, ALL, ALU, 1'b0,
            "alu.in1", {1'b0, ra}, {5'd7, 5'd1, 5'd2});
        // LW x8, -4(x3)
        add_entry(32'hFFC1A403, 32'h0, 32'h1000, 32'h0, 2'b00, ALL, LS, 1'b0,
            "ls.address", 33'h0FFC, {5'd8, 5'd3, 5'd28});
        add_entry(32'hFFC1A403, 32'h0, 32'h1000, 32'h0, 2'b00, ALL, LS, 1'b0,
            "ls.load", 33'h1, {5'd8, 5'd3, 5'd28});
        // SW x4, -8(x3)
        add_entry(32'hFE41AC23, 32'h0, 32'h2000, 32'hCAFEF00D, 2'b00, ALL, LS, 1'b0,
            "ls.address", 33'h1FF8, {5'd24, 5'd3, 5'd4});
        add_entry(32'hFE41AC23, 32'h0, 32'h2000, 32'hCAFEF00D, 2'b00, ALL, LS, 1'b0,
            "ls.store_data", 33'hCAFEF00D, {5'd24, 5'd3, 5'd4});
        // BLTU, BEQ, JALR
        add_entry(32'h0020E863, 32'h0, ra, rb, 2'b00, ALL, BR, 1'b0,
            "br.use_signed", 33'h0, {5'd16, 5'd1, 5'd2});
        add_entry(32'h00208863, 32'h0, ra, rb, 2'b00, ALL, BR, 1'b0,
            "br.use_signed", 33'h1, {5'd16, 5'd1, 5'd2});
        add_entry(32'h00208863, 32'h4440, ra, rb, 2'b00, ALL, BR, 1'b0,
            "br.pc", 33'h4440, {5'd16, 5'd1, 5'd2});
        add_entry(32'h000280E7, 32'h0, ra, 32'h0, 2'b00, ALL, BR, 1'b0,
            "br.jalr", 33'h1, {5'd1, 5'd5, 5'd0});
        // MULHU x9, x1, x2
        add_entry(32'h0220B4B3, 32'h0, ra, rb, 2'b00, ALL, MUL, 1'b0,
            "mul.op", 33'h3, {5'd9, 5'd1, 5'd2});
        // ALU busy, then released
        add_entry(32'h002083B3, 32'h0, ra, rb, 2'b00, NO_ALU, NONE, 1'b0,
            "none", 33'h0, {5'd7, 5'd1, 5'd2});
        add_entry(32'h002083B3, 32'h0, ra, rb, 2'b00, ALL, ALU, 1'b0,
            "alu.in1", {ra[31], ra}, {5'd7, 5'd1, 5'd2});
        // Store data still pending, then written
        add_entry(32'hFE41AC23, 32'h0, 32'h2000, rb, 2'b10, ALL, NONE, 1'b0,
            "none", 33'h0, {5'd24, 5'd3, 5'd4});
        add_entry(32'hFE41AC23, 32'h0, 32'h2000, rb, 2'b00, ALL, LS, 1'b0,
            "ls.store", 33'h1, {5'd24, 5'd3, 5'd4});
        // AMOADD.W is not supported
        add_entry(32'h0021A0AF, 32'h0, 32'h0, 32'h0, 2'b00, ALL, NONE, 1'b1,
            "none", 33'h0, {5'd1, 5'd3, 5'd2});
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        int cycles;
        int errors_before;
        logic popped;
        logic seen_req;
        rst = 1'b1;
        // A valid NOP during reset must leave no request behind
        fb_valid = 1'b1;
        instruction = 32'h00000013;
        pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        rs1_conflict = 1'b0;
        rs2_conflict = 1'b0;
        alu_ready = 1'b1;
        ls_ready = 1'b1;
        br_ready = 1'b1;
        mul_ready = 1'b1;
        load_table();

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        fb_valid <= 1'b0;
        @(negedge clk);
        check_value("pop", 33'(pop), 33'h0);
        check_value("requests", 33'(requests()), 33'h0);

        for (int i = 0; i < num_entries; i++) begin
            errors_before = errors;
            @(posedge clk);
            fb_valid <= 1'b1;
            instruction <= t_instr[i];
            pc <= t_pc[i];
            rs1_data <= t_rs1[i];
            rs2_data <= t_rs2[i];
            rs1_conflict <= t_conflict[i][0];
            rs2_conflict <= t_conflict[i][1];
            alu_ready <= t_ready[i][`DEC_ALU_ID];
            ls_ready <= t_ready[i][`DEC_LS_ID];
            br_ready <= t_ready[i][`DEC_BR_ID];
            mul_ready <= t_ready[i][`DEC_MUL_ID];

            cycles = 0;
            popped = 1'b0;
            seen_req = 1'b0;
            while (!popped && cycles < POP_TIMEOUT) begin
                @(negedge clk);
                seen_req = seen_req | (|requests());
                if (pop) popped = 1'b1;
                else cycles++;
            end
            check_value("illegal_instruction", 33'(illegal_instruction), 33'(t_illegal[i]));
            check_value("rd_addr", 33'(rd_addr), 33'(t_regs[i][14:10]));
            check_value("rs1_addr", 33'(rs1_addr), 33'(t_regs[i][9:5]));
            check_value("rs2_addr", 33'(rs2_addr), 33'(t_regs[i][4:0]));

            if (popped) begin
                if (t_unit[i] == NONE) begin
                    $display("Entry %0d was popped but should have been held", i);
                    errors++;
                end
                check_value("issued_rd", 33'(issued_rd), 33'(writes_rd(t_instr[i])));
                @(posedge clk);
                fb_valid <= 1'b0;
                @(negedge clk);
                check_value("requests", 33'(requests()), 33'(expected_requests(t_unit[i])));
                check_value(t_field[i], field_value(t_field[i]), t_expect[i]);
                // Request lasts a single cycle
                @(negedge clk);
                check_value("requests", 33'(requests()), 33'h0);
            end else begin
                if (t_unit[i] != NONE) begin
                    $display("Entry %0d was not popped within %0d cycles", i, POP_TIMEOUT);
                    errors++;
                end
                check_value("any_request", 33'(seen_req), 33'h0);
            end
            if (errors == errors_before) begin
                $display("Test %0d (%s) ok", i, t_field[i]);
            end else begin
                $display("Test %0d (%s) bad", i, t_field[i]);
            end
        end

        @(posedge clk);
        fb_valid <= 1'b0;
        $display("%0d tests run, %0d errors", num_entries, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: hdl/decode_stage.sv
////////////////////
// Decode and issue stage, one instruction per cycle at most.
// Fetch must hold instruction and pc stable until pop.
// Unit requests and payloads are registered, pop is not.
////////////////////

`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage import decode_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // Fetch buffer
    input  logic                 fb_valid,
    input  logic [`DEC_XLEN-1:0] instruction,
    input  logic [`DEC_XLEN-1:0] pc,
    output logic                 pop,

    // Register file
    output logic [4:0]           rs1_addr,
    output logic [4:0]           rs2_addr,
    input  logic [`DEC_XLEN-1:0] rs1_data,
    input  logic [`DEC_XLEN-1:0] rs2_data,
    input  logic                 rs1_conflict,
    input  logic                 rs2_conflict,

    // Unit readiness
    input  logic                 alu_ready,
    input  logic                 ls_ready,
    input  logic                 br_ready,
    input  logic                 mul_ready,

    // Unit requests
    output logic                 alu_request,
    output alu_inputs_t          alu_inputs,
    output logic                 ls_request,
    output ls_inputs_t           ls_inputs,
    output logic                 br_request,
    output branch_inputs_t       br_inputs,
    output logic                 mul_request,
    output mul_inputs_t          mul_inputs,

    output logic                 illegal_instruction,
    output logic                 issued_rd,
    output logic [4:0]           rd_addr
);

    logic [`DEC_NUM_UNITS-1:0] issue;

    alu_inputs_t    alu_payload;
    ls_inputs_t     ls_payload;
    branch_inputs_t br_payload;
    mul_inputs_t    mul_payload;

    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];
    assign rd_addr = instruction[11:7];

    ////////////////////
    // Issue decision
    ////////////////////
    issue_select u_issue_select (
        .fb_valid            (fb_valid),
        .instruction         (instruction),
        .rs1_conflict        (rs1_conflict),
        .rs2_conflict        (rs2_conflict),
        .alu_ready           (alu_ready),
        .ls_ready            (ls_ready),
        .br_ready            (br_ready),
        .mul_ready           (mul_ready),
        .issue               (issue),
        .pop                 (pop),
        .illegal_instruction (illegal_instruction),
        .issued_rd           (issued_rd)
    );

    ////////////////////
    // Payload construction
    ////////////////////
    arith_operand_gen u_arith_operand_gen (
        .instruction (instruction),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_payload (alu_payload),
        .mul_payload (mul_payload)
    );

    mem_branch_operand_gen u_mem_branch_operand_gen (
        .instruction (instruction),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ls_payload  (ls_payload),
        .br_payload  (br_payload)
    );

    ////////////////////
    // Unit issue registers
    ////////////////////
    unit_issue_reg #(.payload_t(alu_inputs_t)) u_alu_reg (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue[`DEC_ALU_ID]),
        .payload_in  (alu_payload),
        .new_request (alu_request),
        .payload_out (alu_inputs)
    );

    unit_issue_reg #(.payload_t(ls_inputs_t)) u_ls_reg (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue[`DEC_LS_ID]),
        .payload_in  (ls_payload),
        .new_request (ls_request),
        .payload_out (ls_inputs)
    );

    unit_issue_reg #(.payload_t(branch_inputs_t)) u_br_reg (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue[`DEC_BR_ID]),
        .payload_in  (br_payload),
        .new_request (br_request),
        .payload_out (br_inputs)
    );

    unit_issue_reg #(.payload_t(mul_inputs_t)) u_mul_reg (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue[`DEC_MUL_ID]),
        .payload_in  (mul_payload),
        .new_request (mul_request),
        .payload_out (mul_inputs)
    );

endmodule

// File: hdl/unit_issue_reg.sv
////////////////////
// Per-unit issue register, request one cycle after issue.
// Payload holds until the next issue to the same unit.
////////////////////

`timescale 1ns/1ps

module unit_issue_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  payload_t payload_in,
    output logic     new_request,
    output payload_t payload_out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            new_request <= 1'b0;
        end else begin
            new_request <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            payload_out <= payload_in;
        end
    end

endmodule

// File: hdl/mem_branch_operand_gen.sv
////////////////////
// Load/store and branch payloads.
// Address is computed here, the LS unit does no add.
////////////////////

`timescale 1ns/1ps
`include "decode_cfg.svh"

module mem_branch_operand_gen import decode_pkg::*; (
    input  logic [`DEC_XLEN-1:0] instruction,
    input  logic [`DEC_XLEN-1:0] pc,
    input  logic [`DEC_XLEN-1:0] rs1_data,
    input  logic [`DEC_XLEN-1:0] rs2_data,
    output ls_inputs_t           ls_payload,
    output branch_inputs_t       br_payload
);

    localparam int XLEN = `DEC_XLEN;

    opcode_trim_t opcode;
    logic [2:0] fn3;
    logic [11:0] ls_offset;

    assign opcode = opcode_trim_t'(instruction[6:2]);
    assign fn3 = instruction[14:12];

    ////////////////////
    // Load/store
    ////////////////////

    // Bit 5 separates STORE (S form) from LOAD (I form)
    assign ls_offset = instruction[5] ? {instruction[31:25], instruction[11:7]} :
        instruction[31:20];

    assign ls_payload.address = rs1_data + XLEN'(signed'(ls_offset));
    assign ls_payload.store_data = rs2_data;
    assign ls_payload.fn3 = fn3;
    assign ls_payload.load = (opcode == LOAD);
    assign ls_payload.store = (opcode == STORE);
    assign ls_payload.spare = '0;

    ////////////////////
    // Branch and jump
    ////////////////////
    assign br_payload.rs1 = rs1_data;
    assign br_payload.rs2 = rs2_data;
    assign br_payload.pc = pc;
    assign br_payload.fn3 = fn3;
    // BLTU and BGEU
    assign br_payload.use_signed = !(fn3 inside {3'b110, 3'b111});
    assign br_payload.jal = (opcode == JAL);
    assign br_payload.jalr = (opcode == JALR);
    assign br_payload.spare = '0;

endmodule

// File: hdl/arith_operand_gen.sv
////////////////////
// ALU and multiply operand payloads.
// Output is only meaningful for ALU and multiply opcodes.
////////////////////

`timescale 1ns/1ps
`include "decode_cfg.svh"

module arith_operand_gen import decode_pkg::*; (
    input  logic [`DEC_XLEN-1:0] instruction,
    input  logic [`DEC_XLEN-1:0] pc,
    input  logic [`DEC_XLEN-1:0] rs1_data,
    input  logic [`DEC_XLEN-1:0] rs2_data,
    output alu_inputs_t          alu_payload,
    output mul_inputs_t          mul_payload
);

    localparam int XLEN = `DEC_XLEN;

    opcode_trim_t opcode;
    logic [2:0] fn3;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic unsigned_cmp;

    assign opcode = opcode_trim_t'(instruction[6:2]);
    assign fn3 = instruction[14:12];

    ////////////////////
    // ALU operand sources
    ////////////////////
    always_comb begin
        case (opcode)
            LUI: op1 = '0;
            AUIPC, JAL, JALR: op1 = pc;
            default: op1 = rs1_data;
        endcase

        case (opcode)
            LUI, AUIPC: op2 = {instruction[31:12], 12'b0};
            ARITH_IMM: op2 = XLEN'(signed'(instruction[31:20]));
            // Link value pc + 4
            JAL, JALR: op2 = XLEN'(4);
            default: op2 = rs2_data;
        endcase
    end

    // SLTU and SLTIU compare zero-extended
    assign unsigned_cmp = (opcode inside {ARITH, ARITH_IMM}) && (fn3 == 3'b011);

    assign alu_payload.in1 = {op1[XLEN-1] & ~unsigned_cmp, op1};
    assign alu_payload.in2 = {op2[XLEN-1] & ~unsigned_cmp, op2};
    assign alu_payload.subtract = (opcode == ARITH) && instruction[30];
    assign alu_payload.arith_shift = instruction[30];
    assign alu_payload.fn3 = fn3;

    ////////////////////
    // Multiply
    ////////////////////
    assign mul_payload.rs1 = rs1_data;
    assign mul_payload.rs2 = rs2_data;
    assign mul_payload.op = fn3[1:0];

endmodule

// File: hdl/issue_select.sv
////////////////////
// Unit selection and issue decision, purely combinational.
// Holds while a used operand conflicts or the unit is busy.
// Divide encodings are illegal, no divider is present.
////////////////////

`timescale 1ns/1ps
`include "decode_cfg.svh"

module issue_select import decode_pkg::*; (
    input  logic                      fb_valid,
    input  logic [`DEC_XLEN-1:0]      instruction,
    input  logic                      rs1_conflict,
    input  logic                      rs2_conflict,
    input  logic                      alu_ready,
    input  logic                      ls_ready,
    input  logic                      br_ready,
    input  logic                      mul_ready,
    output logic [`DEC_NUM_UNITS-1:0] issue,
    output logic                      pop,
    output logic                      illegal_instruction,
    output logic                      issued_rd
);

    opcode_trim_t opcode;
    logic [2:0] fn3;
    logic [4:0] rd;
    logic mul_div_op;
    logic known_opcode;
    logic legal;
    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;
    logic operands_ready;
    logic can_issue;
    logic [`DEC_NUM_UNITS-1:0] unit_request;
    logic [`DEC_NUM_UNITS-1:0] unit_ready;

    assign opcode = opcode_trim_t'(instruction[6:2]);
    assign fn3 = instruction[14:12];
    assign rd = instruction[11:7];
    assign mul_div_op = (opcode == ARITH) && instruction[25];

    ////////////////////
    // Legality
    ////////////////////

    // 32-bit encodings only, so the low opcode bits must be 11
    assign known_opcode = (instruction[1:0] == 2'b11) &&
        (opcode inside {LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, ARITH_IMM, ARITH});

    assign legal = known_opcode && !(mul_div_op && ((`DEC_USE_MUL == 0) || fn3[2]));

    ////////////////////
    // Unit selection
    ////////////////////
    always_comb begin
        unit_request = '0;
        unit_request[`DEC_ALU_ID] = (opcode inside {LUI, AUIPC, ARITH_IMM}) ||
            ((opcode == ARITH) && !instruction[25]);
        unit_request[`DEC_LS_ID] = opcode inside {LOAD, STORE};
        unit_request[`DEC_BR_ID] = opcode inside {BRANCH, JAL, JALR};
        // Divide also lands here but is never legal
        unit_request[`DEC_MUL_ID] = mul_div_op;
    end

    always_comb begin
        unit_ready = '0;
        unit_ready[`DEC_ALU_ID] = alu_ready;
        unit_ready[`DEC_LS_ID] = ls_ready;
        unit_ready[`DEC_BR_ID] = br_ready;
        unit_ready[`DEC_MUL_ID] = mul_ready;
    end

    ////////////////////
    // Operand hazards
    ////////////////////
    assign uses_rs1 = !(opcode inside {LUI, AUIPC, JAL});
    assign uses_rs2 = opcode inside {BRANCH, STORE, ARITH};
    assign uses_rd = !(opcode inside {BRANCH, STORE});

    assign operands_ready = !(uses_rs1 && rs1_conflict) && !(uses_rs2 && rs2_conflict);

    ////////////////////
    // Issue
    ////////////////////
    assign can_issue = fb_valid && legal && operands_ready;
    assign issue = {`DEC_NUM_UNITS{can_issue}} & unit_request & unit_ready;
    assign pop = |issue;

    // Never popped, fetch side has to drop it
    assign illegal_instruction = fb_valid && !legal;

    // x0 writes need no scoreboard entry
    assign issued_rd = pop && uses_rd && (rd != 5'd0);

endmodule

// File: hdl/decode_pkg.sv
////////////////////
// Opcode encoding and unit payload types.
// Payload widths follow DEC_XLEN from the config header.
////////////////////

`include "decode_cfg.svh"

package decode_pkg;

    ////////////////////
    // Major opcodes, instruction bits 6:2
    ////////////////////
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011
    } opcode_trim_t;

    ////////////////////
    // Unit payloads
    ////////////////////

    // Operands carry one extra sign bit for compares
    typedef struct packed {
        logic [`DEC_XLEN:0] in1;
        logic [`DEC_XLEN:0] in2;
        logic               subtract;
        logic               arith_shift;
        logic [2:0]         fn3;
    } alu_inputs_t;

    // op is fn3[1:0]: MUL, MULH, MULHSU, MULHU
    typedef struct packed {
        logic [`DEC_XLEN-1:0] rs1;
        logic [`DEC_XLEN-1:0] rs2;
        logic [1:0]           op;
    } mul_inputs_t;

    typedef struct packed {
        logic                 spare;
        logic [`DEC_XLEN-1:0] address;
        logic [`DEC_XLEN-1:0] store_data;
        logic [2:0]           fn3;
        logic                 load;
        logic                 store;
    } ls_inputs_t;

    typedef struct packed {
        logic [1:0]           spare;
        logic [`DEC_XLEN-1:0] rs1;
        logic [`DEC_XLEN-1:0] rs2;
        logic [`DEC_XLEN-1:0] pc;
        logic [2:0]           fn3;
        logic                 use_signed;
        logic                 jal;
        logic                 jalr;
    } branch_inputs_t;

endpackage

// File: include/decode_cfg.svh
////////////////////
// Decode and issue configuration for the RV32IM subset.
// Unit indices must stay distinct and below DEC_NUM_UNITS.
// DEC_USE_MUL = 0 makes every M-extension encoding illegal.
////////////////////

`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

////////////////////
// Datapath
////////////////////

// Register data and PC width
`define DEC_XLEN 32

////////////////////
// Execution units
////////////////////

`define DEC_NUM_UNITS 4

// Bit positions in the issue, request and ready vectors
`define DEC_ALU_ID 0
`define DEC_LS_ID  1
`define DEC_BR_ID  2
`define DEC_MUL_ID 3

// Multiply unit present
`define DEC_USE_MUL 1

`endif
